/* src/converter_pkg.sv */
`default_nettype none

package converter_pkg;

   // --------------------------------------------------
   // tank adc channels
   // --------------------------------------------------
   localparam int ADC_W = 14;
   localparam logic signed [ADC_W-1:0] ADC_POS_FULL = 14'sh1FFF;
   localparam logic signed [ADC_W-1:0] ADC_NEG_FULL = 14'sh2000;
   // shifts the signed mirror to offset binary for the dac
   localparam logic [ADC_W-1:0] DAC_OFFSET = 14'd8191;

   // --------------------------------------------------
   // angle setpoints
   // --------------------------------------------------
   localparam int ANGLE_W = 8;
   // phase angle phi
   localparam logic [ANGLE_W-1:0] PHI_STEP = 8'd5;
   localparam logic [ANGLE_W-1:0] PHI_MIN = 8'd0;
   localparam logic [ANGLE_W-1:0] PHI_MAX = 8'd90;
   localparam logic [ANGLE_W-1:0] PHI_RST = 8'd0;
   // zvs offset delta
   localparam logic [ANGLE_W-1:0] DELTA_STEP = 8'd1;
   localparam logic [ANGLE_W-1:0] DELTA_MIN = 8'd0;
   localparam logic [ANGLE_W-1:0] DELTA_MAX = 8'd40;
   localparam logic [ANGLE_W-1:0] DELTA_RST = 8'd0;

   // --------------------------------------------------
   // h-bridge gate path
   // --------------------------------------------------
   // leg 1 is switches 0 and 2, leg 2 is switches 1 and 3
   localparam int N_SW = 4;
   localparam int DT_SEL_W = 2;
   localparam int DT_CNT_W = 8;
   // dead time in clocks, indexed by select code
   localparam logic [DT_CNT_W-1:0] DT_CYCLES_00 = 8'd10;
   localparam logic [DT_CNT_W-1:0] DT_CYCLES_10 = 8'd20;
   localparam logic [DT_CNT_W-1:0] DT_CYCLES_01 = 8'd40;
   localparam logic [DT_CNT_W-1:0] DT_CYCLES_11 = 8'd60;

   // startup timing
   localparam int START_TICK_CYCLES = 100;
   localparam int PRESC_W = $clog2(START_TICK_CYCLES);
   localparam int START_CNT_W = 8;
   localparam logic [START_CNT_W-1:0] BOOT_END = 8'd10;
   localparam logic [START_CNT_W-1:0] FORCE_END = 8'd16;
   // low sides on to charge bootstrap caps
   localparam logic [N_SW-1:0] GATE_BOOT = 4'b1100;
   // one fixed switching state, switches 0 and 3
   localparam logic [N_SW-1:0] GATE_FORCE = 4'b1001;

endpackage

`default_nettype wire

/* src/adc_conditioner.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_conditioner (
   input  logic                                    ADA_DCO,
   input  logic                                    i_rst,
   input  logic signed [converter_pkg::ADC_W-1:0]  i_data,
   input  logic                                    i_over_range,
   output logic signed [converter_pkg::ADC_W-1:0]  o_sample,
   output logic        [converter_pkg::ADC_W-1:0]  o_dac
);

   import converter_pkg::*;

   // sensor polarity is inverted on the board
   logic signed [ADC_W-1:0] neg_data;

   // two's complement negation, wraps for the most negative code
   assign neg_data = -i_data;

   // --------------------------------------------------
   // sample and mirror registers
   // --------------------------------------------------
   always_ff @(posedge ADA_DCO) begin
      if (i_rst) begin
         o_sample <= '0;
         o_dac <= '0;
      end else begin
         if (i_over_range) begin
            // saturate to full scale of inverted polarity
            if (i_data == ADC_NEG_FULL) begin
               o_sample <= ADC_POS_FULL;
            end else begin
               o_sample <= ADC_NEG_FULL;
            end
         end else begin
            o_sample <= neg_data;
         end
         // mirror ignores over-range
         // offset binary, wraps in 14 bits
         o_dac <= $unsigned(neg_data) + DAC_OFFSET;
      end
   end

endmodule

`default_nettype wire

/* src/setpoint_stepper.sv */
`timescale 1ns/1ps
`default_nettype none

module setpoint_stepper #(
   parameter logic [converter_pkg::ANGLE_W-1:0] STEP    = 8'd1,
   parameter logic [converter_pkg::ANGLE_W-1:0] MIN_VAL = 8'd0,
   parameter logic [converter_pkg::ANGLE_W-1:0] MAX_VAL = 8'd255,
   parameter logic [converter_pkg::ANGLE_W-1:0] RST_VAL = 8'd0
) (
   input  logic                                ADA_DCO,
   input  logic                                i_rst,
   input  logic                                i_clear,
   input  logic                                i_inc,
   input  logic                                i_dec,
   output logic [converter_pkg::ANGLE_W-1:0]   o_value
);

   import converter_pkg::*;

   // previous button levels
   logic inc_q;
   logic dec_q;
   // registered rising edges
   logic inc_edge;
   logic dec_edge;
   logic [ANGLE_W-1:0] value_next;

   // --------------------------------------------------
   // edge detect
   // --------------------------------------------------
   always_ff @(posedge ADA_DCO) begin
      if (i_rst) begin
         inc_q <= 1'b0;
         dec_q <= 1'b0;
         inc_edge <= 1'b0;
         dec_edge <= 1'b0;
      end else begin
         inc_q <= i_inc;
         dec_q <= i_dec;
         // one pulse per press, held button steps once
         inc_edge <= i_inc & ~inc_q;
         dec_edge <= i_dec & ~dec_q;
      end
   end

   // saturating step
   // distance to the limit avoids wrap past 8 bits
   always_comb begin
      value_next = o_value;
      if (inc_edge && !dec_edge) begin
         if ((MAX_VAL - o_value) < STEP) begin
            value_next = MAX_VAL;
         end else begin
            value_next = o_value + STEP;
         end
      end else if (dec_edge && !inc_edge) begin
         if ((o_value - MIN_VAL) < STEP) begin
            value_next = MIN_VAL;
         end else begin
            value_next = o_value - STEP;
         end
      end
   end

   // clear wins over any pending step
   always_ff @(posedge ADA_DCO) begin
      if (i_rst || i_clear) begin
         o_value <= RST_VAL;
      end else begin
         o_value <= value_next;
      end
   end

endmodule

`default_nettype wire

/* src/dead_time_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module dead_time_gen (
   input  logic                                  ADA_DCO,
   input  logic                                  i_rst,
   input  logic [converter_pkg::N_SW-1:0]        i_cmd,
   input  logic [converter_pkg::DT_SEL_W-1:0]    i_dt_sel,
   output logic [converter_pkg::N_SW-1:0]        o_cmd
);

   import converter_pkg::*;

   // dead time for current select
   logic [DT_CNT_W-1:0] dt_len;
   // consecutive high edges per switch
   logic [DT_CNT_W-1:0] cnt [N_SW];
   logic [DT_CNT_W-1:0] cnt_next [N_SW];

   // --------------------------------------------------
   // dead-time table lookup
   // --------------------------------------------------
   always_comb begin
      case (i_dt_sel)
         2'b00: dt_len = DT_CYCLES_00;
         2'b10: dt_len = DT_CYCLES_10;
         2'b01: dt_len = DT_CYCLES_01;
         default: dt_len = DT_CYCLES_11;
      endcase
   end

   // count includes the edge being sampled now
   // saturates at all ones so a long on time stays on
   always_comb begin
      for (int i = 0; i < N_SW; i++) begin
         if (!i_cmd[i]) begin
            cnt_next[i] = '0;
         end else if (cnt[i] == '1) begin
            cnt_next[i] = cnt[i];
         end else begin
            cnt_next[i] = cnt[i] + 1'b1;
         end
      end
   end

   // turn-on after dt_len high edges
   // turn-off on the first low edge
   always_ff @(posedge ADA_DCO) begin
      if (i_rst) begin
         for (int i = 0; i < N_SW; i++) begin
            cnt[i] <= '0;
         end
         o_cmd <= '0;
      end else begin
         for (int i = 0; i < N_SW; i++) begin
            cnt[i] <= cnt_next[i];
            o_cmd[i] <= (cnt_next[i] >= dt_len);
         end
      end
   end

endmodule

`default_nettype wire

/* src/bridge_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module bridge_sequencer (
   input  logic                            ADA_DCO,
   input  logic                            i_rst,
   input  logic                            i_enable,
   input  logic [converter_pkg::N_SW-1:0]  i_cmd,
   output logic [converter_pkg::N_SW-1:0]  o_gate,
   output logic                            o_running
);

   import converter_pkg::*;

   localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(START_TICK_CYCLES - 1);

   // startup tick prescaler
   logic [PRESC_W-1:0] presc;
   logic tick;
   // startup phase counter
   logic [START_CNT_W-1:0] start_cnt;
   logic phase_boot;
   logic phase_force;
   logic phase_normal;
   // both switches of one leg requested
   logic shoot_through;

   assign tick = (presc == PRESC_LAST);

   // --------------------------------------------------
   // phase decode
   // --------------------------------------------------
   assign phase_boot = (start_cnt <= BOOT_END);
   assign phase_force = (start_cnt > BOOT_END) && (start_cnt <= FORCE_END);
   assign phase_normal = (start_cnt > FORCE_END);

   // leg 1 is 0 and 2, leg 2 is 1 and 3
   assign shoot_through = (i_cmd[0] & i_cmd[2]) | (i_cmd[1] & i_cmd[3]);

   // --------------------------------------------------
   // startup counters
   // --------------------------------------------------
   // disable restarts the whole sequence from bootstrap
   always_ff @(posedge ADA_DCO) begin
      if (i_rst || !i_enable) begin
         presc <= '0;
         start_cnt <= '0;
      end else if (!phase_normal) begin
         if (tick) begin
            presc <= '0;
            start_cnt <= start_cnt + 1'b1;
         end else begin
            presc <= presc + 1'b1;
         end
      end
   end

   // --------------------------------------------------
   // gate output register
   // --------------------------------------------------
   always_ff @(posedge ADA_DCO) begin
      if (i_rst || !i_enable) begin
         o_gate <= '0;
         o_running <= 1'b0;
      end else begin
         if (phase_boot) begin
            // low sides charge the bootstrap caps
            o_gate <= GATE_BOOT;
         end else if (phase_force) begin
            o_gate <= GATE_FORCE;
         end else if (shoot_through) begin
            // guard only needed for external pattern
            o_gate <= '0;
         end else begin
            o_gate <= i_cmd;
         end
         o_running <= phase_normal;
      end
   end

endmodule

`default_nettype wire

/* src/converter_top.sv */
`timescale 1ns/1ps
`default_nettype none

module converter_top (
   input  logic                                    ADA_DCO,
   input  logic                                    i_rst,
   // tank adcs
   input  logic signed [converter_pkg::ADC_W-1:0]  i_ada_data,
   input  logic signed [converter_pkg::ADC_W-1:0]  i_adb_data,
   input  logic                                    i_ada_or,
   input  logic                                    i_adb_or,
   // setpoint buttons
   input  logic                                    i_btn_rst,
   input  logic                                    i_btn_inc,
   input  logic                                    i_btn_dec,
   input  logic                                    i_btn_delta,
   // bridge control
   input  logic                                    i_enable,
   input  logic [converter_pkg::DT_SEL_W-1:0]      i_dt_sel,
   input  logic [converter_pkg::N_SW-1:0]          i_leg_cmd,
   // conditioned samples and dac mirrors
   output logic signed [converter_pkg::ADC_W-1:0]  o_vc,
   output logic signed [converter_pkg::ADC_W-1:0]  o_ic,
   output logic        [converter_pkg::ADC_W-1:0]  o_dac_a,
   output logic        [converter_pkg::ADC_W-1:0]  o_dac_b,
   // setpoints for the external control law
   output logic [converter_pkg::ANGLE_W-1:0]       o_phi,
   output logic [converter_pkg::ANGLE_W-1:0]       o_delta,
   // gate drives
   output logic [converter_pkg::N_SW-1:0]          o_gate,
   output logic                                    o_running
);

   import converter_pkg::*;

   // request after dead time
   logic [N_SW-1:0] dt_cmd;

   // --------------------------------------------------
   // adc front end
   // --------------------------------------------------
   // channel a is tank voltage
   adc_conditioner u_adc_a (
      .ADA_DCO      (ADA_DCO),
      .i_rst        (i_rst),
      .i_data       (i_ada_data),
      .i_over_range (i_ada_or),
      .o_sample     (o_vc),
      .o_dac        (o_dac_a)
   );

   // channel b is tank current
   adc_conditioner u_adc_b (
      .ADA_DCO      (ADA_DCO),
      .i_rst        (i_rst),
      .i_data       (i_adb_data),
      .i_over_range (i_adb_or),
      .o_sample     (o_ic),
      .o_dac        (o_dac_b)
   );

   // --------------------------------------------------
   // angle setpoints
   // --------------------------------------------------
   setpoint_stepper #(
      .STEP    (PHI_STEP),
      .MIN_VAL (PHI_MIN),
      .MAX_VAL (PHI_MAX),
      .RST_VAL (PHI_RST)
   ) u_phi (
      .ADA_DCO (ADA_DCO),
      .i_rst   (i_rst),
      .i_clear (i_btn_rst),
      .i_inc   (i_btn_inc),
      .i_dec   (i_btn_dec),
      .o_value (o_phi)
   );

   // delta only steps up, back to zero on reset
   setpoint_stepper #(
      .STEP    (DELTA_STEP),
      .MIN_VAL (DELTA_MIN),
      .MAX_VAL (DELTA_MAX),
      .RST_VAL (DELTA_RST)
   ) u_delta (
      .ADA_DCO (ADA_DCO),
      .i_rst   (i_rst),
      .i_clear (1'b0),
      .i_inc   (i_btn_delta),
      .i_dec   (1'b0),
      .o_value (o_delta)
   );

   // --------------------------------------------------
   // gate path
   // --------------------------------------------------
   dead_time_gen u_dead_time (
      .ADA_DCO  (ADA_DCO),
      .i_rst    (i_rst),
      .i_cmd    (i_leg_cmd),
      .i_dt_sel (i_dt_sel),
      .o_cmd    (dt_cmd)
   );

   bridge_sequencer u_sequencer (
      .ADA_DCO   (ADA_DCO),
      .i_rst     (i_rst),
      .i_enable  (i_enable),
      .i_cmd     (dt_cmd),
      .o_gate    (o_gate),
      .o_running (o_running)
   );

endmodule

`default_nettype wire

/* tests/converter_props.sv */
`timescale 1ns/1ps
`default_nettype none

module converter_props (
   input logic                           ADA_DCO,
   input logic                           i_rst,
   input logic                           i_enable,
   input logic [converter_pkg::N_SW-1:0] o_gate,
   input logic [converter_pkg::ANGLE_W-1:0] o_phi,
   input logic [converter_pkg::ANGLE_W-1:0] o_delta
);

   import converter_pkg::*;

   // --------------------------------------------------
   // gate safety
   // --------------------------------------------------
   // leg 1 is switches 0 and 2
   a_leg1_safe: assert property (@(posedge ADA_DCO) disable iff (i_rst)
                                 !(o_gate[0] && o_gate[2]))
      else $error("leg 1 gates on together");
   // leg 2 is switches 1 and 3
   a_leg2_safe: assert property (@(posedge ADA_DCO) disable iff (i_rst)
                                 !(o_gate[1] && o_gate[3]))
      else $error("leg 2 gates on together");
   a_disable_off: assert property (@(posedge ADA_DCO) disable iff (i_rst)
                                   !i_enable |=> (o_gate == '0))
      else $error("gates still on after disable");

   // setpoint limits
   a_phi_limit: assert property (@(posedge ADA_DCO) disable iff (i_rst)
                                 o_phi <= PHI_MAX)
      else $error("phi above its limit");
   a_delta_limit: assert property (@(posedge ADA_DCO) disable iff (i_rst)
                                   o_delta <= DELTA_MAX)
      else $error("delta above its limit");

endmodule

bind converter_top converter_props u_props (
   .ADA_DCO  (ADA_DCO),
   .i_rst    (i_rst),
   .i_enable (i_enable),
   .o_gate   (o_gate),
   .o_phi    (o_phi),
   .o_delta  (o_delta)
);

`default_nettype wire

/* tests/converter_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module converter_tb;

   import converter_pkg::*;

   localparam int SEED = 61590;
   localparam int ADC_TEST_CYCLES = 500;
   localparam int RANDOM_PRESSES = 60;
   // each directed or random press takes at most 10 cycles
   localparam int STEP_TEST_CYCLES = (45 + 4 + RANDOM_PRESSES) * 10;
   localparam int STARTUP_CYCLES = (int'(FORCE_END) + 2) * START_TICK_CYCLES;
   localparam int DT_SEGMENTS = 30;
   localparam int DT_TEST_CYCLES = DT_SEGMENTS * 70;
   localparam int GUARD_TEST_CYCLES = 2 * (int'(DT_CYCLES_11) + 4) + 220;
   // twice the expected run length
   localparam int MAX_CYCLES = 2 * (ADC_TEST_CYCLES + STEP_TEST_CYCLES + STARTUP_CYCLES
                                    + DT_TEST_CYCLES + GUARD_TEST_CYCLES);

   // dut ports
   logic ADA_DCO;
   logic i_rst;
   logic signed [ADC_W-1:0] i_ada_data;
   logic signed [ADC_W-1:0] i_adb_data;
   logic i_ada_or;
   logic i_adb_or;
   logic i_btn_rst;
   logic i_btn_inc;
   logic i_btn_dec;
   logic i_btn_delta;
   logic i_enable;
   logic [DT_SEL_W-1:0] i_dt_sel;
   logic [N_SW-1:0] i_leg_cmd;
   logic signed [ADC_W-1:0] o_vc;
   logic signed [ADC_W-1:0] o_ic;
   logic [ADC_W-1:0] o_dac_a;
   logic [ADC_W-1:0] o_dac_b;
   logic [ANGLE_W-1:0] o_phi;
   logic [ANGLE_W-1:0] o_delta;
   logic [N_SW-1:0] o_gate;
   logic o_running;

   // reference model state
   logic signed [ADC_W-1:0] m_vc;
   logic signed [ADC_W-1:0] m_ic;
   logic [ADC_W-1:0] m_dac_a;
   logic [ADC_W-1:0] m_dac_b;
   logic [ANGLE_W-1:0] m_phi;
   logic [ANGLE_W-1:0] m_delta;
   logic m_inc_q;
   logic m_dec_q;
   logic m_dlt_q;
   logic m_inc_edge;
   logic m_dec_edge;
   logic m_dlt_edge;
   // high run length per switch request
   int m_run [N_SW];
   logic [N_SW-1:0] m_dt;
   logic [N_SW-1:0] m_gate_exp;
   logic m_en_q = 1'b0;
   logic m_rst_q = 1'b1;
   // sequencer phase tracker
   // 0 is bootstrap, 1 forced and 2 normal
   int phase = 0;
   logic seen_boot = 1'b0;
   int cycle_cnt = 0;

   converter_top uut (
      .ADA_DCO     (ADA_DCO),
      .i_rst       (i_rst),
      .i_ada_data  (i_ada_data),
      .i_adb_data  (i_adb_data),
      .i_ada_or    (i_ada_or),
      .i_adb_or    (i_adb_or),
      .i_btn_rst   (i_btn_rst),
      .i_btn_inc   (i_btn_inc),
      .i_btn_dec   (i_btn_dec),
      .i_btn_delta (i_btn_delta),
      .i_enable    (i_enable),
      .i_dt_sel    (i_dt_sel),
      .i_leg_cmd   (i_leg_cmd),
      .o_vc        (o_vc),
      .o_ic        (o_ic),
      .o_dac_a     (o_dac_a),
      .o_dac_b     (o_dac_b),
      .o_phi       (o_phi),
      .o_delta     (o_delta),
      .o_gate      (o_gate),
      .o_running   (o_running)
   );

   always #10 ADA_DCO = ~ADA_DCO;

   // --------------------------------------------------
   // model helpers
   // --------------------------------------------------
   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped after a failed check");
   endtask

   // inverted polarity, full scale on over-range
   function automatic logic signed [ADC_W-1:0] expect_sample(
         input logic signed [ADC_W-1:0] raw, input logic ovr);
      if (!ovr) begin
         return ADC_W'(-int'(raw));
      end
      if (raw == ADC_NEG_FULL) begin
         return ADC_POS_FULL;
      end
      return ADC_NEG_FULL;
   endfunction

   // offset binary mirror of the inverted code
   function automatic logic [ADC_W-1:0] expect_dac(input logic signed [ADC_W-1:0] raw);
      return ADC_W'(int'(DAC_OFFSET) - int'(raw));
   endfunction

   function automatic logic [ANGLE_W-1:0] step_value(input logic [ANGLE_W-1:0] v,
         input logic up, input logic down, input int stp, input int lo, input int hi);
      int n;
      n = int'(v);
      if (up && !down) begin
         n = (n + stp > hi) ? hi : n + stp;
      end else if (down && !up) begin
         n = (n - stp < lo) ? lo : n - stp;
      end
      return ANGLE_W'(n);
   endfunction

   function automatic int dead_cycles(input logic [DT_SEL_W-1:0] sel);
      case (sel)
         2'b00: return int'(DT_CYCLES_00);
         2'b10: return int'(DT_CYCLES_10);
         2'b01: return int'(DT_CYCLES_01);
         default: return int'(DT_CYCLES_11);
      endcase
   endfunction

   // both switches of a leg on means all off
   function automatic logic [N_SW-1:0] apply_leg_guard(input logic [N_SW-1:0] p);
      if ((p[0] && p[2]) || (p[1] && p[3])) begin
         return '0;
      end
      return p;
   endfunction

   function automatic logic [N_SW-1:0] random_safe_pattern();
      logic [N_SW-1:0] p;
      p = N_SW'($urandom);
      // drop one switch of a shorted leg
      if (p[0] && p[2]) begin
         if ($urandom % 2 == 0) p[0] = 1'b0;
         else p[2] = 1'b0;
      end
      if (p[1] && p[3]) begin
         if ($urandom % 2 == 0) p[1] = 1'b0;
         else p[3] = 1'b0;
      end
      return p;
   endfunction

   // --------------------------------------------------
   // reference model, updated on the dut edge
   // --------------------------------------------------
   always @(posedge ADA_DCO) begin
      // gate register sees the dead-time output from before this edge
      m_gate_exp = apply_leg_guard(m_dt);
      m_en_q = i_enable && !i_rst;
      m_rst_q = i_rst;
      if (i_rst) begin
         m_vc = '0;
         m_ic = '0;
         m_dac_a = '0;
         m_dac_b = '0;
         m_phi = PHI_RST;
         m_delta = DELTA_RST;
         {m_inc_q, m_dec_q, m_dlt_q} = '0;
         {m_inc_edge, m_dec_edge, m_dlt_edge} = '0;
         for (int i = 0; i < N_SW; i++) m_run[i] = 0;
         m_dt = '0;
      end else begin
         m_vc = expect_sample(i_ada_data, i_ada_or);
         m_ic = expect_sample(i_adb_data, i_adb_or);
         m_dac_a = expect_dac(i_ada_data);
         m_dac_b = expect_dac(i_adb_data);
         // step from edges seen one clock earlier
         if (i_btn_rst) begin
            m_phi = PHI_RST;
         end else begin
            m_phi = step_value(m_phi, m_inc_edge, m_dec_edge, int'(PHI_STEP),
                               int'(PHI_MIN), int'(PHI_MAX));
         end
         m_delta = step_value(m_delta, m_dlt_edge, 1'b0, int'(DELTA_STEP),
                              int'(DELTA_MIN), int'(DELTA_MAX));
         m_inc_edge = i_btn_inc && !m_inc_q;
         m_dec_edge = i_btn_dec && !m_dec_q;
         m_dlt_edge = i_btn_delta && !m_dlt_q;
         m_inc_q = i_btn_inc;
         m_dec_q = i_btn_dec;
         m_dlt_q = i_btn_delta;
         for (int i = 0; i < N_SW; i++) begin
            m_run[i] = i_leg_cmd[i] ? m_run[i] + 1 : 0;
            m_dt[i] = (m_run[i] >= dead_cycles(i_dt_sel));
         end
      end
   end

   // --------------------------------------------------
   // output checks on the falling edge
   // --------------------------------------------------
   always @(negedge ADA_DCO) begin
      if (!m_rst_q) begin
         assert (o_vc == m_vc && o_ic == m_ic) else
            fail_run($sformatf("[ERROR] %0t ns: samples %h %h, expected %h %h",
                               $time, o_vc, o_ic, m_vc, m_ic));
         assert (o_dac_a == m_dac_a && o_dac_b == m_dac_b) else
            fail_run($sformatf("[ERROR] %0t ns: dac %h %h, expected %h %h",
                               $time, o_dac_a, o_dac_b, m_dac_a, m_dac_b));
         assert (o_phi == m_phi && o_delta == m_delta) else
            fail_run($sformatf("[ERROR] %0t ns: phi %0d delta %0d, expected %0d %0d",
                               $time, o_phi, o_delta, m_phi, m_delta));
         if (!m_en_q) begin
            assert (o_gate == '0 && !o_running) else
               fail_run($sformatf("[ERROR] %0t ns: gate %b running %b while disabled",
                                  $time, o_gate, o_running));
            phase = 0;
            seen_boot = 1'b0;
         end else if (o_running) begin
            assert (phase == 2 || (phase == 1 && seen_boot)) else
               fail_run("switching started before bootstrap and forced phases were both seen");
            phase = 2;
            assert (o_gate == m_gate_exp) else
               fail_run($sformatf("[ERROR] %0t ns: gate %b, expected %b",
                                  $time, o_gate, m_gate_exp));
         end else begin
            assert (phase != 2) else
               fail_run("running dropped while enable stayed high");
            if (o_gate == GATE_BOOT) begin
               assert (phase == 0) else
                  fail_run("bootstrap pattern came back after the forced phase");
               seen_boot = 1'b1;
            end else begin
               assert (o_gate == GATE_FORCE) else
                  fail_run($sformatf("[ERROR] %0t ns: gate %b during startup",
                                     $time, o_gate));
               phase = 1;
            end
         end
      end
   end

   // run limit
   always @(posedge ADA_DCO) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         fail_run("timeout, the test did not finish within the cycle limit");
      end
   end

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------
   task automatic next_cycle();
      @(posedge ADA_DCO);
      #2;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) next_cycle();
   endtask

   // hold 3 to 5 cycles, then release as long
   task automatic press_buttons(input logic clr, input logic inc, input logic dec,
                                input logic dlt);
      i_btn_rst = clr;
      i_btn_inc = inc;
      i_btn_dec = dec;
      i_btn_delta = dlt;
      wait_cycles(3 + int'($urandom % 3));
      {i_btn_rst, i_btn_inc, i_btn_dec, i_btn_delta} = '0;
      wait_cycles(3 + int'($urandom % 3));
   endtask

   initial begin
      void'($urandom(SEED));
      ADA_DCO = 1'b0;
      i_rst = 1'b1;
      i_ada_data = '0;
      i_adb_data = '0;
      i_ada_or = 1'b0;
      i_adb_or = 1'b0;
      {i_btn_rst, i_btn_inc, i_btn_dec, i_btn_delta} = '0;
      i_enable = 1'b0;
      i_dt_sel = '0;
      i_leg_cmd = '0;
      wait_cycles(2);
      i_rst = 1'b0;

      // over-range corner codes first
      i_ada_data = ADC_NEG_FULL;
      i_ada_or = 1'b1;
      i_adb_data = 14'sh0123;
      i_adb_or = 1'b1;
      next_cycle();
      i_ada_data = 14'sh1555;
      i_adb_data = ADC_NEG_FULL;
      i_adb_or = 1'b0;
      next_cycle();
      repeat (ADC_TEST_CYCLES) begin
         i_ada_data = ADC_W'($urandom);
         i_adb_data = ADC_W'($urandom);
         i_ada_or = ($urandom % 8 == 0);
         i_adb_or = ($urandom % 8 == 0);
         next_cycle();
      end

      // drive both setpoints into their upper clamps
      repeat (45) press_buttons(1'b0, 1'b1, 1'b0, 1'b1);
      press_buttons(1'b1, 1'b0, 1'b0, 1'b0);
      // lower clamp from zero
      repeat (3) press_buttons(1'b0, 1'b0, 1'b1, 1'b0);
      repeat (RANDOM_PRESSES) begin
         press_buttons($urandom % 16 == 0, $urandom % 2 == 0, $urandom % 3 == 0,
                       $urandom % 2 == 0);
      end

      // startup with a live request unlike either fixed pattern
      do begin
         i_leg_cmd = random_safe_pattern();
      end while (i_leg_cmd == GATE_BOOT || i_leg_cmd == GATE_FORCE);
      i_dt_sel = DT_SEL_W'($urandom);
      i_enable = 1'b1;
      while (!o_running) next_cycle();

      // --------------------------------------------------
      // dead time in the normal phase
      // --------------------------------------------------
      repeat (DT_SEGMENTS) begin
         i_leg_cmd = random_safe_pattern();
         if ($urandom % 4 == 0) i_dt_sel = DT_SEL_W'($urandom);
         wait_cycles(1 + int'($urandom % 70));
      end

      // shoot-through on each leg
      i_leg_cmd = 4'b0101;
      wait_cycles(int'(DT_CYCLES_11) + 4);
      assert (o_gate == '0) else
         fail_run($sformatf("[ERROR] %0t ns: leg 1 short gave gate %b", $time, o_gate));
      i_leg_cmd = 4'b1010;
      wait_cycles(int'(DT_CYCLES_11) + 4);
      assert (o_gate == '0) else
         fail_run($sformatf("[ERROR] %0t ns: leg 2 short gave gate %b", $time, o_gate));

      // disable, then restart from bootstrap
      i_enable = 1'b0;
      next_cycle();
      assert (o_gate == '0 && !o_running) else
         fail_run($sformatf("[ERROR] %0t ns: gate %b after disable", $time, o_gate));
      wait_cycles(5);
      i_leg_cmd = random_safe_pattern();
      i_enable = 1'b1;
      next_cycle();
      assert (o_gate == GATE_BOOT && !o_running) else
         fail_run($sformatf("[ERROR] %0t ns: gate %b after re-enable", $time, o_gate));
      wait_cycles(200);

      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
src/converter_pkg.sv
src/adc_conditioner.sv
src/setpoint_stepper.sv
src/dead_time_gen.sv
src/bridge_sequencer.sv
src/converter_top.sv
tests/converter_props.sv
tests/converter_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module converter_tb -f sim.f -o converter_sim \
   && ./obj_dir/converter_sim | tee /dev/stderr | grep -q ">>> PASS" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
